/* src/st_pkg.sv */
//////////////////////////////
// User stream beat definitions
// Gen2 carries the full beat, gen1 only the lower bytes
// Byte counts are fixed here, not per instance
//////////////////////////////

package st_pkg;

  //////////////////////////////
  // Widths

  // Bytes in a full gen2 beat
  localparam int ST_DATA_BYTES = 8;

  // Valid bytes when running gen1
  localparam int ST_GEN1_BYTES = 4;

  // Data bits per beat
  localparam int ST_DATA_W = ST_DATA_BYTES * 8;

  //////////////////////////////
  // Beat layout

  // tdata in the upper bits, tlast at bit 0
  typedef struct packed {
    logic [ST_DATA_W-1:0]     tdata;
    logic [ST_DATA_BYTES-1:0] tkeep;
    logic                     tlast;
  } st_beat_t;

endpackage

/* src/link_pkg.sv */
//////////////////////////////
// Link side layouts of the receive adapter
// One PHY lane, words arrive already aligned
// Debug word is 32 bits, spare bits read as zero
// Needs st_pkg compiled first
//////////////////////////////

package link_pkg;

  // Settling delay value width
  localparam int DELAY_W = 16;

  // Drop counter width, counter saturates
  localparam int DROP_W = 16;

  // Fill level width as reported
  localparam int LEVEL_W = 8;

  //////////////////////////////
  // PHY word, one per clock

  // Marker and strobe are lane framing only
  typedef struct packed {
    logic             strobe;
    logic             marker;
    logic             push;
    st_pkg::st_beat_t beat;
  } phy_word_t;

  //////////////////////////////
  // Debug status word

  // dropped in the top half, spare bits at the bottom
  typedef struct packed {
    logic [DROP_W-1:0]  dropped;
    logic               overflow;
    logic [LEVEL_W-1:0] level;
    logic               online;
    logic [5:0]         spare;
  } rx_debug_t;

endpackage

/* src/link_rx_decode.sv */
//////////////////////////////
// Receive decode of one PHY lane
// Online rises delay_x_value + 1 clocks after rx_online
// Only words with push set are forwarded
// Early pushes are counted, count saturates
//////////////////////////////

module link_rx_decode (
  input  logic                         clk_wr,
  input  logic                         rst_n,
  input  logic                         rx_online,
  input  logic [link_pkg::DELAY_W-1:0] delay_x_value,
  input  link_pkg::phy_word_t          rx_phy,
  output logic                         push,
  output st_pkg::st_beat_t             beat,
  output logic                         online,
  output logic [link_pkg::DROP_W-1:0]  dropped
);

  // Settling counter
  logic [link_pkg::DELAY_W-1:0] settle_cnt;
  logic                         settle_done;

  // Word qualifiers
  logic                         fwd_word;
  logic                         early_word;

  //////////////////////////////
  // Settling delay

  // Compare with >= so a lowered delay still ends the wait
  assign settle_done = (settle_cnt >= delay_x_value);

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      settle_cnt <= '0;
      online     <= 1'b0;
    end else if (!rx_online) begin
      // Link dropped, start over
      settle_cnt <= '0;
      online     <= 1'b0;
    end else if (!online) begin
      if (settle_done) begin
        online <= 1'b1;
      end else begin
        settle_cnt <= settle_cnt + 1'b1;
      end
    end
  end

  //////////////////////////////
  // Word decode

  // Forward only while settled
  assign fwd_word   = rx_phy.push && online;
  // Pushed too early, lost
  assign early_word = rx_phy.push && !online;

  // One cycle push strobe
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      push <= 1'b0;
    end else begin
      push <= fwd_word;
    end
  end

  // Beat payload, marker and strobe bits dropped here
  always_ff @(posedge clk_wr) begin
    if (fwd_word) begin
      beat <= rx_phy.beat;
    end
  end

  // Drop counter, holds at all ones
  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      dropped <= '0;
    end else if (early_word && (dropped != '1)) begin
      dropped <= dropped + 1'b1;
    end
  end

endmodule

/* src/link_rx_fifo.sv */
//////////////////////////////
// Show-ahead FIFO with credit return
// Head is registered, valid one clock after first push
// Push while full is lost and flags overflow until reset
// DEPTH up to 255 so level fits 8 bits
//////////////////////////////

module link_rx_fifo #(
  parameter int  DEPTH  = 16,
  parameter type item_t = logic
) (
  input  logic       clk_wr,
  input  logic       rst_n,
  input  logic       push,
  input  item_t      din,
  input  logic       pop,
  output item_t      head,
  output logic       valid,
  output logic       credit,
  output logic       overflow,
  output logic [7:0] level
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  // Storage and pointers
  item_t            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_nxt;
  logic [PTR_W-1:0] rd_nxt;
  logic [CNT_W-1:0] count;

  // Qualified requests
  logic             full;
  logic             do_pop;
  logic             do_push;

  assign full    = (count == CNT_W'(DEPTH));
  assign valid   = (count != '0);
  assign do_pop  = pop && valid;
  // A pop frees a slot in the same cycle
  assign do_push = push && (!full || do_pop);

  // Wrap explicitly, DEPTH need not be a power of two
  assign wr_nxt = (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
  assign rd_nxt = (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;

  assign level = 8'(count);

  //////////////////////////////
  // Pointers and count

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_nxt;
      end
      if (do_pop) begin
        rd_ptr <= rd_nxt;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  //////////////////////////////
  // Storage and head

  always_ff @(posedge clk_wr) begin
    if (do_push) begin
      mem[wr_ptr] <= din;
    end
  end

  // Head mirrors mem[rd_ptr]; bypass din when it lands on the head slot
  always_ff @(posedge clk_wr) begin
    if (do_pop && (count != CNT_W'(1))) begin
      head <= mem[rd_nxt];
    end else if (do_push && (do_pop || !valid)) begin
      head <= din;
    end
  end

  //////////////////////////////
  // Credit and overflow

  always_ff @(posedge clk_wr) begin
    if (!rst_n) begin
      credit   <= 1'b0;
      overflow <= 1'b0;
    end else begin
      credit <= do_pop;
      // Sticky
      if (push && !do_push) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

/* src/st_user_egress.sv */
//////////////////////////////
// FIFO head to user stream port
// Purely combinational, tvalid follows FIFO valid
// Gen1 clears bytes above ST_GEN1_BYTES
//////////////////////////////

module st_user_egress (
  input  logic                             m_gen2_mode,
  input  st_pkg::st_beat_t                 head,
  input  logic                             valid,
  output logic                             pop,
  output logic [st_pkg::ST_DATA_W-1:0]     user_tdata,
  output logic [st_pkg::ST_DATA_BYTES-1:0] user_tkeep,
  output logic                             user_tlast,
  output logic                             user_tvalid,
  input  logic                             user_tready
);

  // Per byte lane enable for the current mode
  logic [st_pkg::ST_DATA_BYTES-1:0] byte_en;

  //////////////////////////////
  // Lane masking

  // Gen2 keeps all lanes
  always_comb begin
    for (int i = 0; i < st_pkg::ST_DATA_BYTES; i++) begin
      byte_en[i] = m_gen2_mode || (i < st_pkg::ST_GEN1_BYTES);
    end
  end

  // Data bytes cleared per lane
  always_comb begin
    for (int i = 0; i < st_pkg::ST_DATA_BYTES; i++) begin
      user_tdata[i*8 +: 8] = head.tdata[i*8 +: 8] & {8{byte_en[i]}};
    end
  end

  // Keep cleared on the same lanes
  assign user_tkeep = head.tkeep & byte_en;
  assign user_tlast = head.tlast;

  //////////////////////////////
  // Handshake

  assign user_tvalid = valid;
  // Transfer pops the head
  assign pop = valid && user_tready;

endmodule

/* src/link_rx_top.sv */
//////////////////////////////
// Receive half of the die-to-die stream adapter
// Single clock clk_wr, single PHY lane
// Sender starts with DEPTH credits, one back per transfer
// Push to user tvalid is two clocks when empty
//////////////////////////////

module link_rx_top #(
  parameter int DEPTH = 16
) (
  input  logic                             clk_wr,
  input  logic                             rst_n,
  input  logic                             rx_online,
  input  logic [link_pkg::DELAY_W-1:0]     delay_x_value,
  input  logic                             m_gen2_mode,
  input  link_pkg::phy_word_t              rx_phy,
  output logic                             tx_credit,
  output logic [st_pkg::ST_DATA_W-1:0]     user_tdata,
  output logic [st_pkg::ST_DATA_BYTES-1:0] user_tkeep,
  output logic                             user_tlast,
  output logic                             user_tvalid,
  input  logic                             user_tready,
  output link_pkg::rx_debug_t              rx_debug_status
);

  // Decode outputs
  logic                          dec_push;
  st_pkg::st_beat_t              dec_beat;
  logic                          dec_online;
  logic [link_pkg::DROP_W-1:0]   dec_dropped;

  // FIFO outputs
  st_pkg::st_beat_t              fifo_head;
  logic                          fifo_valid;
  logic                          fifo_overflow;
  logic [link_pkg::LEVEL_W-1:0]  fifo_level;

  // Egress pop back to FIFO
  logic                          egr_pop;

  //////////////////////////////
  // PHY decode

  link_rx_decode u_decode (
    .clk_wr        (clk_wr),
    .rst_n         (rst_n),
    .rx_online     (rx_online),
    .delay_x_value (delay_x_value),
    .rx_phy        (rx_phy),
    .push          (dec_push),
    .beat          (dec_beat),
    .online        (dec_online),
    .dropped       (dec_dropped)
  );

  //////////////////////////////
  // Receive FIFO

  link_rx_fifo #(
    .DEPTH  (DEPTH),
    .item_t (st_pkg::st_beat_t)
  ) u_fifo (
    .clk_wr   (clk_wr),
    .rst_n    (rst_n),
    .push     (dec_push),
    .din      (dec_beat),
    .pop      (egr_pop),
    .head     (fifo_head),
    .valid    (fifo_valid),
    .credit   (tx_credit),
    .overflow (fifo_overflow),
    .level    (fifo_level)
  );

  //////////////////////////////
  // User port

  st_user_egress u_egress (
    .m_gen2_mode (m_gen2_mode),
    .head        (fifo_head),
    .valid       (fifo_valid),
    .pop         (egr_pop),
    .user_tdata  (user_tdata),
    .user_tkeep  (user_tkeep),
    .user_tlast  (user_tlast),
    .user_tvalid (user_tvalid),
    .user_tready (user_tready)
  );

  // Debug word, spare bits zero
  always_comb begin
    rx_debug_status          = '0;
    rx_debug_status.dropped  = dec_dropped;
    rx_debug_status.overflow = fifo_overflow;
    rx_debug_status.level    = fifo_level;
    rx_debug_status.online   = dec_online;
  end

endmodule

/* tests/tb_link_rx_model.svh */
//////////////////////////////
// Reference model of the receive adapter
// Beats stored unmasked, gen1 rule applied at compare
// Included inside tb_link_rx, DEPTH must exist first
//////////////////////////////

`ifndef TB_LINK_RX_MODEL_SVH
`define TB_LINK_RX_MODEL_SVH

// Beats the FIFO should hold, oldest first
st_pkg::st_beat_t exp_q[$];

// Event counters and sticky flag
int unsigned drop_cnt;
int unsigned credit_cnt;
int unsigned xfer_cnt;
logic        ovf_flag;

// Gen1 keeps only the lower ST_GEN1_BYTES lanes
function automatic st_pkg::st_beat_t mask_beat(input st_pkg::st_beat_t b,
                                               input logic gen2);
  st_pkg::st_beat_t m;
  m = b;
  if (!gen2) begin
    m.tdata[st_pkg::ST_DATA_W-1:st_pkg::ST_GEN1_BYTES*8] = '0;
    m.tkeep[st_pkg::ST_DATA_BYTES-1:st_pkg::ST_GEN1_BYTES] = '0;
  end
  return m;
endfunction

task automatic model_clear();
  exp_q.delete();
  drop_cnt   = 0;
  credit_cnt = 0;
  xfer_cnt   = 0;
  ovf_flag   = 1'b0;
endtask

// Early push, counter holds at its maximum
task automatic model_drop();
  if (drop_cnt < 32'h0000_FFFF) begin
    drop_cnt++;
  end
endtask

// One FIFO clock edge, pop frees room before the push
task automatic model_edge(input logic pop, input logic push, input st_pkg::st_beat_t b);
  if (pop && (exp_q.size() != 0)) begin
    void'(exp_q.pop_front());
  end
  if (push) begin
    if (exp_q.size() < DEPTH) begin
      exp_q.push_back(b);
    end else begin
      // Full and no pop, beat lost
      ovf_flag = 1'b1;
    end
  end
endtask

`endif

/* tests/tb_link_rx.sv */
//////////////////////////////
// Testbench for link_rx_top
// Inputs driven 1 unit after rising edge
// Outputs checked at the falling edge against the model
// Settling delay fixed at 20 for the whole run
//////////////////////////////

module tb_link_rx;

  localparam int DEPTH      = 16;
  // Phases take roughly 1000 cycles, rest is margin
  localparam int MAX_CYCLES = 4000;

  // DUT ports
  logic                             clk_wr;
  logic                             rst_n;
  logic                             rx_online;
  logic [link_pkg::DELAY_W-1:0]     delay_x_value;
  logic                             m_gen2_mode;
  link_pkg::phy_word_t              rx_phy;
  logic                             tx_credit;
  logic [st_pkg::ST_DATA_W-1:0]     user_tdata;
  logic [st_pkg::ST_DATA_BYTES-1:0] user_tkeep;
  logic                             user_tlast;
  logic                             user_tvalid;
  logic                             user_tready;
  link_pkg::rx_debug_t              rx_debug_status;

  // Run bookkeeping
  integer seed;
  int     errors;
  int     checks;
  int     cycles;
  int     credits_held;

  // Monitor state mirroring the pipeline
  logic                             pend_push;
  st_pkg::st_beat_t                 pend_beat;
  st_pkg::st_beat_t                 exp_beat;
  int                               hi_cnt;
  logic                             model_online;
  logic                             exp_credit;
  logic                             pop_now;
  logic                             hold_prev;
  logic                             prev_tready;
  logic [st_pkg::ST_DATA_W-1:0]     prev_tdata;
  logic [st_pkg::ST_DATA_BYTES-1:0] prev_tkeep;
  logic                             prev_tlast;

  `include "tb_link_rx_model.svh"

  link_rx_top #(
    .DEPTH (DEPTH)
  ) DUT (
    .clk_wr          (clk_wr),
    .rst_n           (rst_n),
    .rx_online       (rx_online),
    .delay_x_value   (delay_x_value),
    .m_gen2_mode     (m_gen2_mode),
    .rx_phy          (rx_phy),
    .tx_credit       (tx_credit),
    .user_tdata      (user_tdata),
    .user_tkeep      (user_tkeep),
    .user_tlast      (user_tlast),
    .user_tvalid     (user_tvalid),
    .user_tready     (user_tready),
    .rx_debug_status (rx_debug_status)
  );

  initial begin
    clk_wr = 1'b0;
    forever #5 clk_wr = ~clk_wr;
  end

  //////////////////////////////
  // Check helpers

  task automatic compare_field(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
    checks++;
    assert (expected === actual) else begin
      errors++;
      $display("Mismatch at %0t: %s expected %h, actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  //////////////////////////////
  // Stimulus helpers

  task automatic next_cycle();
    @(posedge clk_wr);
    #1;
  endtask

  // Random payload, marker and strobe are noise
  task automatic drive_word(input logic do_push);
    link_pkg::phy_word_t w;
    w.strobe      = {$random(seed)} % 2;
    w.marker      = {$random(seed)} % 2;
    w.push        = do_push;
    w.beat.tdata  = {$random(seed), $random(seed)};
    w.beat.tkeep  = $random(seed);
    w.beat.tlast  = {$random(seed)} % 2;
    rx_phy        = w;
  endtask

  // ready_mode 0 high, 1 random, otherwise low
  task automatic send_traffic(input int n, input int push_pct, input int ready_mode);
    logic want;
    repeat (n) begin
      next_cycle();
      case (ready_mode)
        0:       user_tready = 1'b1;
        1:       user_tready = {$random(seed)} % 2;
        default: user_tready = 1'b0;
      endcase
      want = ({$random(seed)} % 100) < push_pct;
      if (want && (credits_held > 0)) begin
        credits_held--;
        drive_word(1'b1);
      end else begin
        drive_word(1'b0);
      end
    end
  endtask

  // Idle until tvalid stays low a few cycles
  task automatic drain();
    int idle;
    idle = 0;
    while (idle < 4) begin
      next_cycle();
      drive_word(1'b0);
      user_tready = 1'b1;
      if (user_tvalid) begin
        idle = 0;
      end else begin
        idle++;
      end
    end
  endtask

  //////////////////////////////
  // Monitor and model

  always @(negedge clk_wr) begin
    if (!rst_n) begin
      model_clear();
      pend_push    = 1'b0;
      hi_cnt       = 0;
      model_online = 1'b0;
      exp_credit   = 1'b0;
      hold_prev    = 1'b0;
      prev_tready  = 1'b1;
      credits_held = DEPTH;
    end else begin
      compare_field("online", model_online, rx_debug_status.online);
      compare_field("dropped", drop_cnt, rx_debug_status.dropped);
      compare_field("overflow", ovf_flag, rx_debug_status.overflow);
      compare_field("level", exp_q.size(), rx_debug_status.level);
      // Unused debug bits read as zero
      compare_field("spare", 0, rx_debug_status.spare);
      compare_field("tx_credit", exp_credit, tx_credit);
      compare_field("user_tvalid", exp_q.size() != 0, user_tvalid);
      if (user_tvalid && (exp_q.size() != 0)) begin
        exp_beat = mask_beat(exp_q[0], m_gen2_mode);
        compare_field("user_tdata", exp_beat.tdata, user_tdata);
        compare_field("user_tkeep", exp_beat.tkeep, user_tkeep);
        compare_field("user_tlast", exp_beat.tlast, user_tlast);
      end
      // Stalled head must not move
      if (hold_prev) begin
        check_true(user_tvalid && (user_tdata === prev_tdata) && (user_tkeep === prev_tkeep)
                   && (user_tlast === prev_tlast), "head changed while user_tready was low");
      end
      if (!prev_tready) begin
        check_true(!tx_credit, "credit returned while user_tready was held low");
      end
      if (tx_credit) begin
        credit_cnt++;
        credits_held++;
      end
      // Events taken at the coming edge
      pop_now     = user_tvalid && user_tready;
      hold_prev   = user_tvalid && !user_tready;
      prev_tready = user_tready;
      prev_tdata  = user_tdata;
      prev_tkeep  = user_tkeep;
      prev_tlast  = user_tlast;
      exp_credit  = pop_now;
      if (pop_now) begin
        xfer_cnt++;
      end
      model_edge(pop_now, pend_push, pend_beat);
      // Decode sees the pre-edge online state
      pend_push = rx_phy.push && model_online;
      pend_beat = rx_phy.beat;
      if (rx_phy.push && !model_online) begin
        model_drop();
      end
      // Online after delay + 1 edges with rx_online high
      if (!rx_online) begin
        hi_cnt       = 0;
        model_online = 1'b0;
      end else if (!model_online) begin
        hi_cnt++;
        model_online = (hi_cnt >= delay_x_value + 1);
      end
    end
  end

  //////////////////////////////
  // Timeout

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk_wr);
      cycles++;
      if (cycles >= MAX_CYCLES) begin
        errors++;
        $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
        $display("Checks: %0d  Errors: %0d", checks, errors);
        $display("Test failures found");
        $finish;
      end
    end
  end

  //////////////////////////////
  // Test sequence

  initial begin
    int sent_early;
    int x0;
    seed          = 29696;
    errors        = 0;
    checks        = 0;
    sent_early    = 0;
    rst_n         = 1'b0;
    rx_online     = 1'b0;
    delay_x_value = 16'd20;
    m_gen2_mode   = 1'b1;
    rx_phy        = '0;
    user_tready   = 1'b1;
    credits_held  = DEPTH;
    repeat (10) @(posedge clk_wr);
    #1;
    rst_n = 1'b1;

    // Pushes before and during settling are dropped
    repeat (5) begin
      next_cycle();
      drive_word(1'b1);
      sent_early++;
    end
    repeat (10) begin
      next_cycle();
      rx_online = 1'b1;
      drive_word(1'b1);
      sent_early++;
    end
    next_cycle();
    drive_word(1'b0);
    while (!rx_debug_status.online) begin
      next_cycle();
    end
    compare_field("dropped", sent_early, rx_debug_status.dropped);

    // Gen2 ordered delivery
    send_traffic(200, 60, 0);
    drain();

    // Gen1 lane masking
    m_gen2_mode = 1'b0;
    send_traffic(200, 60, 0);
    drain();
    m_gen2_mode = 1'b1;

    // Random back-pressure
    send_traffic(300, 70, 1);
    drain();

    // Ready held low, no credit may return
    send_traffic(30, 50, 2);
    drain();

    // Overflow, push past full with ready low
    repeat (DEPTH + 3) begin
      next_cycle();
      user_tready = 1'b0;
      drive_word(1'b1);
    end
    next_cycle();
    drive_word(1'b0);
    repeat (3) next_cycle();
    check_true(rx_debug_status.overflow, "overflow flag not set after pushing past full");
    x0 = xfer_cnt;
    drain();
    compare_field("drained beats", DEPTH, xfer_cnt - x0);

    check_true(exp_q.size() == 0, "expected beats were never delivered");
    compare_field("tx_credit pulses", xfer_cnt, credit_cnt);

    $display("Checks: %0d  Errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+tests
src/st_pkg.sv
src/link_pkg.sv
src/link_rx_decode.sv
src/link_rx_fifo.sv
src/st_user_egress.sv
src/link_rx_top.sv
tests/tb_link_rx.sv
